// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f build.f --top-module cpuCoreTb
	@out="$$(./obj_dir/VcpuCoreTb)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// ==== build.f ====
hdl/cpuPkg.sv
hdl/instrDecode.sv
hdl/aluExecute.sv
hdl/resultRegFile.sv
hdl/controlSequencer.sv
hdl/cpuCore.sv
verif/memModel.sv
verif/cpuCoreTb.sv

// ==== hdl/aluExecute.sv ====
`timescale 1ns/100ps

module aluExecute (
    input  cpuPkg::aluOpT aluOp,
    input  logic          useImm,
    input  cpuPkg::wordT  rs1Val,
    input  cpuPkg::wordT  rs2Val,
    input  cpuPkg::wordT  rdVal,
    input  cpuPkg::wordT  imm,
    input  cpuPkg::wordT  pc,
    output cpuPkg::wordT  aluResult,
    output cpuPkg::wordT  branchTarget,
    output logic          equal
);
    import cpuPkg::*;

    wordT opA;
    wordT opB;
    wordT wordOffset;

    assign opA = rs1Val;

    // immediate forms replace the second register operand.
    assign opB = useImm ? imm : rs2Val;

    always_comb begin
        case (aluOp)
            ADD: begin
                aluResult = opA + opB;
            end
            SUB: begin
                aluResult = opA - opB;
            end
            AND: begin
                aluResult = opA & opB;
            end
            OR: begin
                aluResult = opA | opB;
            end
            XOR: begin
                aluResult = opA ^ opB;
            end
            default: begin
                aluResult = opA + opB;
            end
        endcase
    end

    // BEQ compares rd against rs1, not rs1 against rs2.
    assign equal = (rdVal == rs1Val);

    // displacement counts words, relative to the branch itself.
    assign wordOffset   = {imm[29:0], 2'b00};
    assign branchTarget = pc + wordOffset;

endmodule

// ==== hdl/controlSequencer.sv ====
`timescale 1ns/100ps

module controlSequencer (
    input  logic         clk,
    input  logic         arstN,
    input  logic         memReady,
    input  cpuPkg::wordT memRdata,
    output logic         memValid,
    output logic         memWrite,
    output cpuPkg::wordT memAddr,
    output cpuPkg::wordT memWdata,
    output logic         halted,
    output cpuPkg::wordT ir,
    output cpuPkg::wordT pc,
    input  logic         isLoad,
    input  logic         isStore,
    input  logic         isBranchEq,
    input  logic         isBranchAlways,
    input  logic         isHalt,
    input  logic         regWriteEn,
    input  cpuPkg::wordT aluResult,
    input  cpuPkg::wordT branchTarget,
    input  logic         equal,
    input  cpuPkg::wordT rdVal,
    output logic         wbEn,
    output logic         selLoad,
    output cpuPkg::wordT loadData
);
    import cpuPkg::*;

    seqStateT state;
    wordT     mar;
    wordT     npc;
    wordT     aluReg;
    logic     taken;

    assign taken = isBranchAlways || (isBranchEq && equal);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= FETCH;
            memValid <= 1'b0;
            ir       <= '0;
            pc       <= RESET_PC;
            npc      <= RESET_PC + 32'd4;
        end else begin
            case (state)
                FETCH: begin
                    if (memValid && memReady) begin
                        memValid <= 1'b0;
                        ir       <= memRdata;
                        state    <= DECODE;
                    end else begin
                        memValid <= 1'b1;
                    end
                end
                DECODE: state <= isHalt ? HALTED : EXEC;
                EXEC: begin
                    state <= (isLoad || isStore) ? MEMACC : WRITEB;
                end
                MEMACC: begin
                    if (memValid && memReady) begin
                        memValid <= 1'b0;
                        state    <= WRITEB;
                    end else begin
                        memValid <= 1'b1;
                    end
                end
                WRITEB: begin
                    // delayed branch, the slot after a branch always runs.
                    pc    <= npc;
                    npc   <= taken ? branchTarget : npc + 32'd4;
                    state <= FETCH;
                end
                default: state <= HALTED;
            endcase
        end
    end

    // datapath registers.
    always_ff @(posedge clk) begin
        if (state == EXEC) begin
            aluReg <= aluResult;
        end
        // MAR is set as the data request goes out and then holds.
        if (state == MEMACC && !memValid) begin
            mar <= aluReg;
        end
        if (state == MEMACC && memReady) begin
            loadData <= memRdata;
        end
    end

    assign memAddr  = (state == MEMACC) ? mar : pc;
    assign memWrite = (state == MEMACC) && isStore;
    assign memWdata = rdVal;
    assign halted   = (state == HALTED);
    assign wbEn     = (state == WRITEB) && regWriteEn;
    assign selLoad  = isLoad;

endmodule

// ==== hdl/cpuCore.sv ====
`timescale 1ns/100ps

module cpuCore (
    input  logic         clk,
    input  logic         arstN,
    output logic         memValid,
    output logic         memWrite,
    output cpuPkg::wordT memAddr,
    output cpuPkg::wordT memWdata,
    output logic         halted,
    input  logic         memReady,
    input  cpuPkg::wordT memRdata
);
    import cpuPkg::*;

    wordT   ir;
    wordT   pc;
    wordT   imm;
    wordT   rs1Val;
    wordT   rs2Val;
    wordT   rdVal;
    wordT   aluResult;
    wordT   branchTarget;
    wordT   loadData;
    regIdxT rd;
    regIdxT rs1;
    regIdxT rs2;
    aluOpT  aluOp;
    logic   useImm;
    logic   isLoad;
    logic   isStore;
    logic   isBranchEq;
    logic   isBranchAlways;
    logic   isHalt;
    logic   regWriteEn;
    logic   equal;
    logic   wbEn;
    logic   selLoad;

    controlSequencer sequencer (
        .clk(clk), .arstN(arstN),
        .memReady(memReady), .memRdata(memRdata),
        .memValid(memValid), .memWrite(memWrite),
        .memAddr(memAddr), .memWdata(memWdata),
        .halted(halted), .ir(ir), .pc(pc),
        .isLoad(isLoad), .isStore(isStore),
        .isBranchEq(isBranchEq), .isBranchAlways(isBranchAlways),
        .isHalt(isHalt), .regWriteEn(regWriteEn),
        .aluResult(aluResult), .branchTarget(branchTarget),
        .equal(equal), .rdVal(rdVal),
        .wbEn(wbEn), .selLoad(selLoad), .loadData(loadData)
    );

    instrDecode decode (
        .ir(ir), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
        .aluOp(aluOp), .useImm(useImm),
        .isLoad(isLoad), .isStore(isStore),
        .isBranchEq(isBranchEq), .isBranchAlways(isBranchAlways),
        .isHalt(isHalt), .regWriteEn(regWriteEn)
    );

    aluExecute execute (
        .aluOp(aluOp), .useImm(useImm),
        .rs1Val(rs1Val), .rs2Val(rs2Val), .rdVal(rdVal),
        .imm(imm), .pc(pc),
        .aluResult(aluResult), .branchTarget(branchTarget), .equal(equal)
    );

    resultRegFile regFile (
        .clk(clk), .arstN(arstN),
        .rdIdx(rd), .rs1Idx(rs1), .rs2Idx(rs2),
        .wbEn(wbEn), .selLoad(selLoad),
        .aluResult(aluResult), .loadData(loadData),
        .rs1Val(rs1Val), .rs2Val(rs2Val), .rdVal(rdVal)
    );

endmodule

// ==== hdl/cpuPkg.sv ====
package cpuPkg;

    // a data, address or instruction word.
    typedef logic [31:0] wordT;

    // register index into the 32-entry register file.
    typedef logic [4:0] regIdxT;

    // opcode field, bits 31..26 of the instruction.
    typedef logic [5:0] opcodeT;

    // opcode values, anything else executes as a no-op.
    localparam opcodeT OP_ADD  = 6'h01;
    localparam opcodeT OP_SUB  = 6'h02;
    localparam opcodeT OP_AND  = 6'h03;
    localparam opcodeT OP_OR   = 6'h04;
    localparam opcodeT OP_XOR  = 6'h05;
    localparam opcodeT OP_ADDI = 6'h06;
    localparam opcodeT OP_LDW  = 6'h07;
    localparam opcodeT OP_STW  = 6'h08;
    localparam opcodeT OP_BEQ  = 6'h09;
    localparam opcodeT OP_BA   = 6'h0a;
    localparam opcodeT OP_HALT = 6'h3f;

    // ALU functions.
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR
    } aluOpT;

    // multicycle sequencer states.
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXEC,
        MEMACC,
        WRITEB,
        HALTED
    } seqStateT;

    // first instruction address, nPC starts one word later.
    localparam wordT RESET_PC = 32'h0000_0000;

endpackage

// ==== hdl/instrDecode.sv ====
`timescale 1ns/100ps

module instrDecode (
    input  cpuPkg::wordT   ir,
    output cpuPkg::regIdxT rd,
    output cpuPkg::regIdxT rs1,
    output cpuPkg::regIdxT rs2,
    output cpuPkg::wordT   imm,
    output cpuPkg::aluOpT  aluOp,
    output logic           useImm,
    output logic           isLoad,
    output logic           isStore,
    output logic           isBranchEq,
    output logic           isBranchAlways,
    output logic           isHalt,
    output logic           regWriteEn
);
    import cpuPkg::*;

    opcodeT opcode;

    assign opcode = ir[31:26];
    assign rd     = ir[25:21];
    assign rs1    = ir[20:16];
    assign rs2    = ir[15:11];

    // 16-bit signed immediate widened to a full word.
    assign imm = {{16{ir[15]}}, ir[15:0]};

    always_comb begin
        aluOp          = ADD;
        useImm         = 1'b0;
        isLoad         = 1'b0;
        isStore        = 1'b0;
        isBranchEq     = 1'b0;
        isBranchAlways = 1'b0;
        isHalt         = 1'b0;
        regWriteEn     = 1'b0;
        case (opcode)
            OP_ADD: begin
                regWriteEn = 1'b1;
            end
            OP_SUB: begin
                aluOp      = SUB;
                regWriteEn = 1'b1;
            end
            OP_AND: begin
                aluOp      = AND;
                regWriteEn = 1'b1;
            end
            OP_OR: begin
                aluOp      = OR;
                regWriteEn = 1'b1;
            end
            OP_XOR: begin
                aluOp      = XOR;
                regWriteEn = 1'b1;
            end
            OP_ADDI: begin
                useImm     = 1'b1;
                regWriteEn = 1'b1;
            end
            // address is rs1 plus the immediate for both memory ops.
            OP_LDW: begin
                useImm     = 1'b1;
                isLoad     = 1'b1;
                regWriteEn = 1'b1;
            end
            OP_STW: begin
                useImm  = 1'b1;
                isStore = 1'b1;
            end
            OP_BEQ:  isBranchEq     = 1'b1;
            OP_BA:   isBranchAlways = 1'b1;
            OP_HALT: isHalt         = 1'b1;
            default: ;
        endcase
    end

endmodule

// ==== hdl/resultRegFile.sv ====
`timescale 1ns/100ps

module resultRegFile (
    input  logic           clk,
    input  logic           arstN,
    input  cpuPkg::regIdxT rdIdx,
    input  cpuPkg::regIdxT rs1Idx,
    input  cpuPkg::regIdxT rs2Idx,
    input  logic           wbEn,
    input  logic           selLoad,
    input  cpuPkg::wordT   aluResult,
    input  cpuPkg::wordT   loadData,
    output cpuPkg::wordT   rs1Val,
    output cpuPkg::wordT   rs2Val,
    output cpuPkg::wordT   rdVal
);
    import cpuPkg::*;

    wordT regs [32];
    wordT wbData;

    // loads write the memory word, everything else the ALU result.
    assign wbData = selLoad ? loadData : aluResult;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && (rdIdx != 5'd0)) begin
            regs[rdIdx] <= wbData;
        end
    end

    // r0 reads as zero whatever the array holds.
    assign rs1Val = (rs1Idx == 5'd0) ? '0 : regs[rs1Idx];
    assign rs2Val = (rs2Idx == 5'd0) ? '0 : regs[rs2Idx];
    assign rdVal  = (rdIdx == 5'd0) ? '0 : regs[rdIdx];

endmodule

// ==== verif/cpuCoreTb.sv ====
`timescale 1ns/100ps

module cpuCoreTb;
    import cpuPkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int FETCH_LIMIT = 20;
    localparam int RUN_LIMIT = 3000;
    localparam int QUIET_CYCLES = 20;

    logic clk = 1'b0;
    logic arstN;
    logic memValid;
    logic memWrite;
    wordT memAddr;
    wordT memWdata;
    logic halted;
    logic memReady;
    wordT memRdata;

    wordT expAddr [$];
    wordT expData [$];

    // main flow counters.
    int valueErrors = 0;
    int otherErrors = 0;

    // store monitor counters.
    int storeCount = 0;
    int storeValueErrors = 0;
    int storeOtherErrors = 0;

    cpuCore uut (
        .clk(clk), .arstN(arstN),
        .memValid(memValid), .memWrite(memWrite),
        .memAddr(memAddr), .memWdata(memWdata),
        .halted(halted),
        .memReady(memReady), .memRdata(memRdata)
    );

    memModel mem (
        .clk(clk), .arstN(arstN),
        .memValid(memValid), .memWrite(memWrite),
        .memAddr(memAddr), .memWdata(memWdata),
        .memReady(memReady), .memRdata(memRdata)
    );

    always #50 clk = ~clk;

    task automatic showMismatch(input string name, input wordT expected, input wordT actual);
        $display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic checkLow(input string name, input logic actual);
        if (actual !== 1'b0) begin
            showMismatch(name, 32'd0, {31'd0, actual});
            valueErrors++;
        end
    endtask

    // P lines go into memory from address 0, S lines into the expected store list.
    task automatic loadDataFile();
        int    fd;
        int    n;
        string line;
        byte   tag;
        wordT  a;
        wordT  b;
        wordT  progAddr;
        logic  done;
        progAddr = '0;
        done = 1'b0;
        fd = $fopen("verif/cpuTestdata.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/cpuTestdata.txt");
            otherErrors++;
        end else begin
            while (!done && !$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1) begin
                    tag = line.getc(0);
                    if (tag == "P") begin
                        n = $sscanf(line.substr(1, line.len() - 1), "%h", a);
                        mem.writeWord(progAddr, a);
                        progAddr = progAddr + 32'd4;
                    end else if (tag == "S") begin
                        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                        expAddr.push_back(a);
                        expData.push_back(b);
                    end else if (tag == "E") begin
                        done = 1'b1;
                    end
                end
            end
            $fclose(fd);
            if (!done) begin
                $display("the data file has no end marker");
                otherErrors++;
            end
        end
    endtask

    // every completed write on the bus is compared with the next expected store.
    always @(posedge clk) begin
        if (arstN && memValid && memWrite && memReady) begin
            if (storeCount >= expAddr.size()) begin
                $display("at %0t the core stored %h to %h, more stores than expected",
                         $time, memWdata, memAddr);
                storeOtherErrors++;
            end else begin
                if (memAddr !== expAddr[storeCount]) begin
                    showMismatch("memAddr", expAddr[storeCount], memAddr);
                    storeValueErrors++;
                end
                if (memWdata !== expData[storeCount]) begin
                    showMismatch("memWdata", expData[storeCount], memWdata);
                    storeValueErrors++;
                end
            end
            storeCount++;
        end
    end

    initial begin : mainFlow
        int cycles;
        int totalErrors;
        arstN = 1'b0;
        loadDataFile();

        for (cycles = 0; cycles < RESET_CYCLES; cycles++) begin
            @(negedge clk);
            checkLow("memValid", memValid);
            checkLow("memWrite", memWrite);
            checkLow("halted", halted);
        end
        arstN = 1'b1;

        cycles = 0;
        while (!memValid && cycles < FETCH_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!memValid) begin
            $display("timeout: no fetch request after reset was released");
            otherErrors++;
        end else begin
            // the fetch request starts in the first cycle after release.
            if (cycles != 1) begin
                $display("the first fetch request came %0d cycles after reset was released",
                         cycles);
                otherErrors++;
            end
            // the first request is a read of the reset address.
            checkLow("memWrite", memWrite);
            checkLow("halted", halted);
            if (memAddr !== 32'd0) begin
                showMismatch("memAddr", 32'd0, memAddr);
                valueErrors++;
            end

            cycles = 0;
            while (!halted && cycles < RUN_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (!halted) begin
                $display("timeout: the core did not halt");
                otherErrors++;
            end else begin
                for (cycles = 0; cycles < QUIET_CYCLES; cycles++) begin
                    if (memValid) begin
                        $display("at %0t the core made a request after it halted", $time);
                        otherErrors++;
                    end
                    @(negedge clk);
                end
                if (storeCount != expAddr.size()) begin
                    $display("the core made %0d stores, the data file expects %0d",
                             storeCount, expAddr.size());
                    otherErrors++;
                end
            end
        end

        totalErrors = valueErrors + otherErrors + storeValueErrors + storeOtherErrors;
        $display("errors: %0d value, %0d other; stores seen %0d of %0d",
                 valueErrors + storeValueErrors, otherErrors + storeOtherErrors,
                 storeCount, expAddr.size());
        if (totalErrors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== verif/cpuTestdata.txt ====
# P <word>: program word, placed from address 0 upward
# S <addr> <data>: expected store in bus order; E: end of data
P 18200100
P 18401234
P 18600F0F
P 04821800
P 20810000
P 08A31000
P 20A10004
P 0CC21800
P 20C10008
P 10E21800
P 20E1000C
P 15021800
P 21010010
P 1922ED00
P 21210014
P 1D410004
P 21410018
P 24430004
P 2041001C
P 20610020
P 25450004
P 20410024
P 20610028
P FC000000
P 2081002C
P 28000003
P 20C10030
P 20610034
P 20E10038
P FC000000
S 00000100 00002143
S 00000104 FFFFFCDB
S 00000108 00000204
S 0000010C 00001F3F
S 00000110 00001D3B
S 00000114 FFFFFF34
S 00000118 FFFFFCDB
S 0000011C 00001234
S 00000120 00000F0F
S 00000124 00001234
S 0000012C 00002143
S 00000130 00000204
S 00000138 00001F3F
E

// ==== verif/memModel.sv ====
`timescale 1ns/100ps

module memModel (
    input  logic         clk,
    input  logic         arstN,
    input  logic         memValid,
    input  logic         memWrite,
    input  cpuPkg::wordT memAddr,
    input  cpuPkg::wordT memWdata,
    output logic         memReady,
    output cpuPkg::wordT memRdata
);
    import cpuPkg::*;

    logic [7:0] memBytes [512] = '{default: 8'h00};
    logic       readyReg = 1'b0;
    wordT       rdataReg = '0;
    logic       pending = 1'b0;
    int         waitLeft = 0;
    integer     seed = 32'h4b35362c;

    assign memReady = readyReg;
    assign memRdata = rdataReg;

    // big-endian, the byte at the lowest address is bits 31..24.
    task automatic writeWord(input wordT addr, input wordT data);
        logic [8:0] base;
        base = {addr[8:2], 2'b00};
        memBytes[base]         = data[31:24];
        memBytes[base + 9'd1]  = data[23:16];
        memBytes[base + 9'd2]  = data[15:8];
        memBytes[base + 9'd3]  = data[7:0];
    endtask

    function automatic wordT readWord(input wordT addr);
        logic [8:0] base;
        base = {addr[8:2], 2'b00};
        return {memBytes[base], memBytes[base + 9'd1],
                memBytes[base + 9'd2], memBytes[base + 9'd3]};
    endfunction

    // responses change on the falling edge and the core samples them on the rising edge.
    always @(negedge clk) begin
        if (!arstN) begin
            readyReg <= 1'b0;
            pending = 1'b0;
        end else if (readyReg) begin
            // the core took the response at the last rising edge.
            readyReg <= 1'b0;
            pending = 1'b0;
        end else if (memValid) begin
            if (!pending) begin
                pending  = 1'b1;
                waitLeft = $random(seed) & 3;
            end
            if (waitLeft == 0) begin
                if (memWrite) begin
                    writeWord(memAddr, memWdata);
                end else begin
                    rdataReg <= readWord(memAddr);
                end
                readyReg <= 1'b1;
            end else begin
                waitLeft = waitLeft - 1;
            end
        end
    end

endmodule
